//--- hdl/kbd_pkg.sv
// shared widths, map entry union and key code constants
// for the PS/2 keyboard receiver
`default_nettype none

package kbd_pkg;

	localparam int FRAME_BITS = 11; // start, 8 data, parity, stop
	localparam int SCAN_W     = 8;
	localparam int AKEY_W     = 8;  // bit 7 upstroke, 6..0 raw code

	// table entry seen as an Amiga key
	typedef struct packed {
		logic       valid;
		logic       ctrl;
		logic       lalt;
		logic       ralt;
		logic       caps;
		logic [2:0] reserved;
		logic       marker; // clear for keys
		logic [6:0] code;
	} key_view_t;

	// same entry seen as a PS/2 prefix byte
	typedef struct packed {
		logic [7:0] zero_hi;
		logic       marker; // set for prefixes
		logic [3:0] zero_lo;
		logic       ack;
		logic       rel;
		logic       ext;
	} prefix_view_t;

	typedef union packed {
		key_view_t    key_view;
		prefix_view_t prefix_view;
	} map_entry_t;

	localparam map_entry_t ENTRY_EXT = 16'h0081; // E0
	localparam map_entry_t ENTRY_REL = 16'h0082; // F0
	localparam map_entry_t ENTRY_ACK = 16'h0084; // FA

	// amiga raw codes of the modifier keys
	localparam logic [6:0] CODE_CAPS = 7'h62;
	localparam logic [6:0] CODE_CTRL = 7'h63;
	localparam logic [6:0] CODE_LALT = 7'h64;
	localparam logic [6:0] CODE_RALT = 7'h65;

endpackage

`default_nettype wire

//--- hdl/ps2_rx.sv
// PS/2 frame receiver
// pin synchronizer, clock falling-edge detect and frame shifter
`timescale 1ns/1ps
`default_nettype none

module ps2_rx
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       ps2_clk,
	input  logic                       ps2_dat,
	output logic                       frame_ready,
	output logic [kbd_pkg::SCAN_W-1:0] scan_code
);

logic [1:0]                     clk_sync; // [1] is the synchronized level
logic [1:0]                     dat_sync;
logic                           clk_prev;
logic                           clk_fall;
logic [kbd_pkg::FRAME_BITS-1:0] shifter;

// lines idle high
always_ff @(posedge clk)
begin
	if (reset)
	begin
		clk_sync <= 2'b11;
		dat_sync <= 2'b11;
		clk_prev <= 1'b1;
	end
	else
	begin
		clk_sync <= {clk_sync[0], ps2_clk};
		dat_sync <= {dat_sync[0], ps2_dat};
		clk_prev <= clk_sync[1];
	end
end

assign clk_fall = clk_prev & ~clk_sync[1];

// lsb first, the start bit reaches bit 0 once the whole frame is in
always_ff @(posedge clk)
begin
	if (reset || frame_ready)
		shifter <= '1;
	else if (clk_fall)
		shifter <= {dat_sync[1], shifter[kbd_pkg::FRAME_BITS-1:1]};
end

assign frame_ready = ~shifter[0];
assign scan_code   = shifter[kbd_pkg::SCAN_W:1]; // data bits above the start bit

endmodule

`default_nettype wire

//--- hdl/scan_map.sv
// Set 2 scan code to Amiga raw key table
// plus E0 extended and F0 release prefix tracking
`timescale 1ns/1ps
`default_nettype none

module scan_map
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       frame_ready,
	input  logic [kbd_pkg::SCAN_W-1:0] scan_code,
	output logic                       key_valid,
	output logic [kbd_pkg::AKEY_W-1:0] akey,
	output logic                       is_ctrl,
	output logic                       is_lalt,
	output logic                       is_ralt,
	output logic                       is_caps
);

// modifier flags {ctrl, lalt, ralt, caps}
localparam logic [3:0] MOD_NONE = 4'b0000;
localparam logic [3:0] MOD_CTRL = 4'b1000;
localparam logic [3:0] MOD_LALT = 4'b0100;
localparam logic [3:0] MOD_RALT = 4'b0010;
localparam logic [3:0] MOD_CAPS = 4'b0001;

kbd_pkg::map_entry_t entry;       // table output
logic                entry_valid; // frame_ready, delayed for the table read
logic                extended;
logic                upstroke;

function automatic kbd_pkg::map_entry_t mk_key(input logic [3:0] mods, input logic [6:0] code);
	kbd_pkg::map_entry_t e;
	e = '0;
	e.key_view.valid = 1'b1;
	{e.key_view.ctrl, e.key_view.lalt, e.key_view.ralt, e.key_view.caps} = mods;
	e.key_view.code = code;
	return e;
endfunction

// ----------------------------------------
// index is {extended, scan code}
function automatic kbd_pkg::map_entry_t lookup(input logic [8:0] idx);
	kbd_pkg::map_entry_t e;
	case (idx)
		9'h00d: e = mk_key(MOD_NONE, 7'h42); // tab
		9'h011: e = mk_key(MOD_LALT, kbd_pkg::CODE_LALT);
		9'h012: e = mk_key(MOD_NONE, 7'h60); // left shift
		9'h014: e = mk_key(MOD_CTRL, kbd_pkg::CODE_CTRL);
		9'h015: e = mk_key(MOD_NONE, 7'h10); // q
		9'h016: e = mk_key(MOD_NONE, 7'h01); // 1
		9'h01a: e = mk_key(MOD_NONE, 7'h31); // z
		9'h01b: e = mk_key(MOD_NONE, 7'h21); // s
		9'h01c: e = mk_key(MOD_NONE, 7'h20); // a
		9'h01d: e = mk_key(MOD_NONE, 7'h11); // w
		9'h01e: e = mk_key(MOD_NONE, 7'h02); // 2
		9'h021: e = mk_key(MOD_NONE, 7'h33); // c
		9'h022: e = mk_key(MOD_NONE, 7'h32); // x
		9'h023: e = mk_key(MOD_NONE, 7'h22); // d
		9'h024: e = mk_key(MOD_NONE, 7'h12); // e
		9'h025: e = mk_key(MOD_NONE, 7'h04); // 4
		9'h026: e = mk_key(MOD_NONE, 7'h03); // 3
		9'h029: e = mk_key(MOD_NONE, 7'h40); // space
		9'h02a: e = mk_key(MOD_NONE, 7'h34); // v
		9'h02b: e = mk_key(MOD_NONE, 7'h23); // f
		9'h02c: e = mk_key(MOD_NONE, 7'h14); // t
		9'h02d: e = mk_key(MOD_NONE, 7'h13); // r
		9'h02e: e = mk_key(MOD_NONE, 7'h05); // 5
		9'h031: e = mk_key(MOD_NONE, 7'h36); // n
		9'h032: e = mk_key(MOD_NONE, 7'h35); // b
		9'h033: e = mk_key(MOD_NONE, 7'h25); // h
		9'h034: e = mk_key(MOD_NONE, 7'h24); // g
		9'h035: e = mk_key(MOD_NONE, 7'h15); // y
		9'h036: e = mk_key(MOD_NONE, 7'h06); // 6
		9'h03a: e = mk_key(MOD_NONE, 7'h37); // m
		9'h03b: e = mk_key(MOD_NONE, 7'h26); // j
		9'h03c: e = mk_key(MOD_NONE, 7'h16); // u
		9'h03d: e = mk_key(MOD_NONE, 7'h07); // 7
		9'h03e: e = mk_key(MOD_NONE, 7'h08); // 8
		9'h042: e = mk_key(MOD_NONE, 7'h27); // k
		9'h043: e = mk_key(MOD_NONE, 7'h17); // i
		9'h044: e = mk_key(MOD_NONE, 7'h18); // o
		9'h045: e = mk_key(MOD_NONE, 7'h0a); // 0
		9'h046: e = mk_key(MOD_NONE, 7'h09); // 9
		9'h04b: e = mk_key(MOD_NONE, 7'h28); // l
		9'h04d: e = mk_key(MOD_NONE, 7'h19); // p
		9'h058: e = mk_key(MOD_CAPS, kbd_pkg::CODE_CAPS);
		9'h059: e = mk_key(MOD_NONE, 7'h61); // right shift
		9'h05a: e = mk_key(MOD_NONE, 7'h44); // enter
		9'h066: e = mk_key(MOD_NONE, 7'h41); // backspace
		9'h076: e = mk_key(MOD_NONE, 7'h45); // escape
		9'h111: e = mk_key(MOD_RALT, kbd_pkg::CODE_RALT);
		9'h11f: e = mk_key(MOD_NONE, 7'h66); // left gui, left amiga
		9'h127: e = mk_key(MOD_NONE, 7'h67); // right gui, right amiga
		9'h16b: e = mk_key(MOD_NONE, 7'h4f); // arrow left
		9'h172: e = mk_key(MOD_NONE, 7'h4d); // arrow down
		9'h174: e = mk_key(MOD_NONE, 7'h4e); // arrow right
		9'h175: e = mk_key(MOD_NONE, 7'h4c); // arrow up
		// prefixes decode the same in both halves
		9'h0e0, 9'h1e0: e = kbd_pkg::ENTRY_EXT;
		9'h0f0, 9'h1f0: e = kbd_pkg::ENTRY_REL;
		9'h0fa, 9'h1fa: e = kbd_pkg::ENTRY_ACK;
		default: e = '0;
	endcase
	return e;
endfunction

always_ff @(posedge clk)
	if (frame_ready)
		entry <= lookup({extended, scan_code});

always_ff @(posedge clk)
begin
	if (reset)
		entry_valid <= 1'b0;
	else
		entry_valid <= frame_ready;
end

// ----------------------------------------
// prefix state for the following byte
always_ff @(posedge clk)
begin
	if (reset)
	begin
		extended <= 1'b0;
		upstroke <= 1'b0;
	end
	else if (entry_valid && entry.prefix_view.marker)
	begin
		if (entry.prefix_view.ext)
			extended <= 1'b1;
		if (entry.prefix_view.rel)
			upstroke <= 1'b1;
	end
	else if (entry_valid)
	begin
		extended <= 1'b0; // key or unknown byte ends the sequence
		upstroke <= 1'b0;
	end
end

assign key_valid = entry_valid & entry.key_view.valid;
assign akey      = {upstroke, entry.key_view.code};
assign is_ctrl   = entry.key_view.ctrl;
assign is_lalt   = entry.key_view.lalt;
assign is_ralt   = entry.key_view.ralt;
assign is_caps   = entry.key_view.caps;

endmodule

`default_nettype wire

//--- hdl/typematic_filter.sv
// typematic repeat filter, amiga caps lock emulation
// and keyboard reset chord detector
`timescale 1ns/1ps
`default_nettype none

module typematic_filter
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       key_valid,
	input  logic [kbd_pkg::AKEY_W-1:0] akey,
	input  logic                       is_ctrl,
	input  logic                       is_lalt,
	input  logic                       is_ralt,
	input  logic                       is_caps,
	output logic                       keystrobe,
	output logic [kbd_pkg::AKEY_W-1:0] keydat,
	output logic                       aflock,
	output logic                       kbdrst
);

localparam int UP_BIT = kbd_pkg::AKEY_W - 1;

logic [kbd_pkg::AKEY_W-1:0] last_key;  // last downstroke or its own upstroke
logic                       same_code;
logic                       duplicate;
logic                       caps_state;
logic [2:0]                 chord_up;  // {ctrl or caps, lalt, ralt}, 1 while released

assign same_code = last_key[UP_BIT-1:0] == akey[UP_BIT-1:0];
assign duplicate = same_code && (last_key[UP_BIT] == akey[UP_BIT]);

// ----------------------------------------
always_ff @(posedge clk)
begin
	if (reset)
		last_key <= '0;
	else if (key_valid && !akey[UP_BIT])
		last_key <= akey;
	else if (key_valid && akey[UP_BIT] && same_code)
		last_key <= akey;
end

// caps lock state is kept here, the keyboard never sees it
always_ff @(posedge clk)
begin
	if (reset)
		caps_state <= 1'b0;
	else if (key_valid && !akey[UP_BIT] && is_caps && !duplicate)
		caps_state <= ~caps_state;
end

// caps events swallowed while locked
assign keystrobe = key_valid && !(caps_state && is_caps) && !duplicate;
assign keydat    = akey;
assign aflock    = caps_state;

// ----------------------------------------
// ctrl-alt-alt reset chord
always_ff @(posedge clk)
begin
	if (reset)
		chord_up <= 3'b111;
	else if (key_valid)
	begin
		if (is_ctrl || is_caps)
			chord_up[2] <= akey[UP_BIT];
		if (is_lalt)
			chord_up[1] <= akey[UP_BIT];
		if (is_ralt)
			chord_up[0] <= akey[UP_BIT];
	end
end

assign kbdrst = ~|chord_up; // all three held down

endmodule

`default_nettype wire

//--- hdl/host_hold.sv
// host handshake: holds the PS/2 clock low after a key
// until keyack or the hold timer runs out
`timescale 1ns/1ps
`default_nettype none

module host_hold
#(
	parameter int TIMEOUT_BITS = 20
)
(
	input  logic clk,
	input  logic reset,
	input  logic keystrobe,
	input  logic keyack,
	output logic ps2_clk_low
);

localparam logic ST_WAIT = 1'b0;
localparam logic ST_HOLD = 1'b1;

logic                    state;
logic [TIMEOUT_BITS-1:0] timer;
logic                    timeout;

assign timeout = timer[TIMEOUT_BITS-1]; // saturates here

always_ff @(posedge clk)
begin
	if (reset)
		timer <= '0;
	else if (state == ST_WAIT && keystrobe)
		timer <= '0;
	else if (!timeout)
		timer <= timer + {{(TIMEOUT_BITS-1){1'b0}}, 1'b1};
end

always_ff @(posedge clk)
begin
	if (reset)
		state <= ST_WAIT;
	else
	begin
		case (state)
			ST_WAIT:
				if (keystrobe)
					state <= ST_HOLD;
			default:
				if (keyack || timeout)
					state <= ST_WAIT; // host took it, or gave up
		endcase
	end
end

assign ps2_clk_low = (state == ST_HOLD);

endmodule

`default_nettype wire

//--- hdl/ps2_keyboard.sv
// PS/2 keyboard receiver for an Amiga host
// frame receiver, scan map, typematic filter and host hold in a row
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard
#(
	parameter int TIMEOUT_BITS = 20
)
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       ps2_clk,
	input  logic                       ps2_dat,
	input  logic                       keyack,
	output logic [kbd_pkg::AKEY_W-1:0] keydat,
	output logic                       keystrobe,
	output logic                       aflock,
	output logic                       kbdrst,
	output logic                       ps2_clk_low
);

logic                       frame_ready;
logic [kbd_pkg::SCAN_W-1:0] scan_code;
logic                       key_valid;
logic [kbd_pkg::AKEY_W-1:0] akey;
logic                       is_ctrl;
logic                       is_lalt;
logic                       is_ralt;
logic                       is_caps;

ps2_rx i_rx
(
	.clk         (clk),
	.reset       (reset),
	.ps2_clk     (ps2_clk),
	.ps2_dat     (ps2_dat),
	.frame_ready (frame_ready),
	.scan_code   (scan_code)
);

scan_map i_map
(
	.clk         (clk),
	.reset       (reset),
	.frame_ready (frame_ready),
	.scan_code   (scan_code),
	.key_valid   (key_valid),
	.akey        (akey),
	.is_ctrl     (is_ctrl),
	.is_lalt     (is_lalt),
	.is_ralt     (is_ralt),
	.is_caps     (is_caps)
);

typematic_filter i_filter
(
	.clk       (clk),
	.reset     (reset),
	.key_valid (key_valid),
	.akey      (akey),
	.is_ctrl   (is_ctrl),
	.is_lalt   (is_lalt),
	.is_ralt   (is_ralt),
	.is_caps   (is_caps),
	.keystrobe (keystrobe),
	.keydat    (keydat),
	.aflock    (aflock),
	.kbdrst    (kbdrst)
);

host_hold #(
	.TIMEOUT_BITS (TIMEOUT_BITS)
) i_hold (
	.clk         (clk),
	.reset       (reset),
	.keystrobe   (keystrobe),
	.keyack      (keyack),
	.ps2_clk_low (ps2_clk_low)
);

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// free-running testbench clock
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
	parameter int PERIOD_NS = 10
)
(
	output logic clk
);

initial
begin
	clk = 1'b0;
	forever
		#(PERIOD_NS / 2) clk = ~clk;
end

endmodule

`default_nettype wire

//--- bench/ps2_keyboard_properties.sv
// concurrent checks on the keyboard receiver top level
// keystrobe width, strobe versus clock hold, hold state in reset
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_properties
(
	input logic clk,
	input logic reset,
	input logic keystrobe,
	input logic ps2_clk_low
);

int strobe_len_fails  = 0;
int strobe_hold_fails = 0;
int reset_fails       = 0;

strobe_one_cycle: assert property (@(posedge clk) disable iff (reset) keystrobe |=> !keystrobe)
else
begin
	$error("keystrobe high for more than one cycle");
	strobe_len_fails = strobe_len_fails + 1;
end

// no new key while the keyboard clock is held
strobe_not_held: assert property (@(posedge clk) disable iff (reset) keystrobe |-> !ps2_clk_low)
else
begin
	$error("keystrobe while the PS/2 clock is held low");
	strobe_hold_fails = strobe_hold_fails + 1;
end

hold_clear_in_reset: assert property (@(posedge clk) reset |=> !ps2_clk_low)
else
begin
	$error("PS/2 clock held low during reset");
	reset_fails = reset_fails + 1;
end

endmodule

`default_nettype wire

//--- bench/ps2_keyboard_tb.sv
// testbench for the PS/2 keyboard receiver
// replays golden key vectors, checks strobes, flags and the clock hold
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_tb;

localparam int TIMEOUT_BITS = 8;
localparam int NUM_VECTORS  = 29;
localparam int FIELDS       = 6; // byte, strobe, keydat, aflock, kbdrst, ack
localparam int HALF_BIT     = 3; // clk cycles per PS/2 clock phase
localparam int STROBE_WAIT  = 16;
localparam int QUIET_WAIT   = 10;
localparam int ACK_WAIT     = 4;
localparam int HOLD_LIMIT   = (1 << (TIMEOUT_BITS - 1)) + 2;

logic       clk;
logic       reset;
logic       ps2_clk;
logic       ps2_dat;
logic       keyack;
logic [7:0] keydat;
logic       keystrobe;
logic       aflock;
logic       kbdrst;
logic       ps2_clk_low;

logic [7:0] golden [0:NUM_VECTORS*FIELDS-1];
int         error_count;
int         check_count;
int         assert_count;

tb_clock #(.PERIOD_NS (10)) i_clock (.clk (clk));

ps2_keyboard #(
	.TIMEOUT_BITS (TIMEOUT_BITS)
) i_dut (
	.clk         (clk),
	.reset       (reset),
	.ps2_clk     (ps2_clk),
	.ps2_dat     (ps2_dat),
	.keyack      (keyack),
	.keydat      (keydat),
	.keystrobe   (keystrobe),
	.aflock      (aflock),
	.kbdrst      (kbdrst),
	.ps2_clk_low (ps2_clk_low)
);

bind ps2_keyboard ps2_keyboard_properties i_props
(
	.clk         (clk),
	.reset       (reset),
	.keystrobe   (keystrobe),
	.ps2_clk_low (ps2_clk_low)
);

// ----------------------------------------
task automatic check_value(input string name, input logic [7:0] actual,
	input logic [7:0] expected);
	check_count++;
	if (actual !== expected)
	begin
		error_count++;
		$display("MISMATCH time %0t: %s got %h, expected %h", $time, name, actual, expected);
	end
endtask

task automatic report_failure(input string msg);
	error_count++;
	$display("ERROR time %0t: %s", $time, msg);
endtask

// start, data lsb first, odd parity, stop
task automatic send_frame(input logic [7:0] data);
	logic [kbd_pkg::FRAME_BITS-1:0] frame;
	frame = {1'b1, ~^data, data, 1'b0};
	for (int i = 0; i < kbd_pkg::FRAME_BITS; i++)
	begin
		ps2_dat = frame[i];
		repeat (HALF_BIT) @(negedge clk);
		ps2_clk = 1'b0; // device samples on this edge
		repeat (HALF_BIT) @(negedge clk);
		ps2_clk = 1'b1;
	end
endtask

task automatic watch_strobe(input int limit, output logic seen);
	int waited;
	seen = 1'b0;
	waited = 0;
	while (!seen && waited < limit)
	begin
		@(negedge clk);
		waited++;
		seen = keystrobe;
	end
endtask

task automatic wait_clk_release(input int limit, output logic released);
	int waited;
	released = !ps2_clk_low;
	waited = 0;
	while (!released && waited < limit)
	begin
		@(negedge clk);
		waited++;
		released = !ps2_clk_low;
	end
endtask

task automatic check_flags(input logic [7:0] want_lock, input logic [7:0] want_rst);
	check_value("aflock", {7'd0, aflock}, want_lock);
	check_value("kbdrst", {7'd0, kbdrst}, want_rst);
endtask

// ----------------------------------------
initial
begin
	logic seen;
	logic released;
	int   base;
	reset = 1'b1;
	ps2_clk = 1'b1;
	ps2_dat = 1'b1;
	keyack = 1'b0;
	error_count = 0;
	check_count = 0;
	$readmemh("bench/golden_keys.txt", golden);
	repeat (8) @(negedge clk);
	reset = 1'b0;
	repeat (2) @(negedge clk);
	check_value("keystrobe", {7'd0, keystrobe}, 8'h00);
	check_value("ps2_clk_low", {7'd0, ps2_clk_low}, 8'h00);
	check_flags(8'h00, 8'h00);

	for (int v = 0; v < NUM_VECTORS; v++)
	begin
		base = v * FIELDS;
		wait_clk_release(HOLD_LIMIT, released);
		if (!released)
			report_failure("PS/2 clock still held low before the next frame");
		repeat (2) @(negedge clk); // idle gap between frames
		send_frame(golden[base]);
		if (golden[base+1][0])
		begin
			watch_strobe(STROBE_WAIT, seen);
			if (!seen)
				report_failure($sformatf("no keystrobe after scan byte %h", golden[base]));
			else
			begin
				check_value("keydat", keydat, golden[base+2]);
				@(negedge clk);
				check_flags(golden[base+3], golden[base+4]);
				if (golden[base+5][0])
				begin
					repeat (3) @(negedge clk);
					check_value("ps2_clk_low", {7'd0, ps2_clk_low}, 8'h01);
					keyack = 1'b1;
					@(negedge clk);
					keyack = 1'b0;
					wait_clk_release(ACK_WAIT, released);
					if (!released)
						report_failure("PS/2 clock not released after keyack");
				end
				else
				begin
					wait_clk_release(HOLD_LIMIT, released); // upper bound only
					if (!released)
						report_failure("PS/2 clock not released within the hold timeout");
				end
			end
		end
		else
		begin
			watch_strobe(QUIET_WAIT, seen);
			if (seen)
				report_failure($sformatf("unexpected keystrobe after scan byte %h, keydat %h",
					golden[base], keydat));
			check_flags(golden[base+3], golden[base+4]);
		end
	end

	assert_count = i_dut.i_props.strobe_len_fails + i_dut.i_props.strobe_hold_fails
		+ i_dut.i_props.reset_fails;
	$display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
		assert_count);
	if (error_count == 0 && assert_count == 0)
		$display("STATUS: PASS");
	else
		$display("STATUS: FAIL");
	$finish;
end

endmodule

`default_nettype wire

//--- bench/golden_keys.txt
// scan byte, strobe expected, keydat, aflock, kbdrst, ack (all hex)
// keydat is 00 and unused on lines without a strobe
1c 1 20 0 0 1
f0 0 00 0 0 0
1c 1 a0 0 0 0
1b 1 21 0 0 1
1b 0 00 0 0 0
1b 0 00 0 0 0
2b 1 23 0 0 1
1b 1 21 0 0 1
f0 0 00 0 0 0
1b 1 a1 0 0 1
f0 0 00 0 0 0
2b 1 a3 0 0 1
e0 0 00 0 0 0
75 1 4c 0 0 1
e0 0 00 0 0 0
f0 0 00 0 0 0
75 1 cc 0 0 1
58 1 62 1 0 1
f0 0 00 1 0 0
58 0 00 1 0 0
58 0 00 0 0 0
f0 0 00 0 0 0
58 1 e2 0 0 1
14 1 63 0 0 1
11 1 64 0 0 1
e0 0 00 0 0 0
11 1 65 0 1 1
f0 0 00 0 1 0
11 1 e4 0 0 0

//--- sim.f
hdl/kbd_pkg.sv
hdl/ps2_rx.sv
hdl/scan_map.sv
hdl/typematic_filter.sv
hdl/host_hold.sv
hdl/ps2_keyboard.sv
bench/tb_clock.sv
bench/ps2_keyboard_properties.sv
bench/ps2_keyboard_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
	--top-module ps2_keyboard_tb -Mdir obj_dir -o ps2_keyboard_sim \
	&& ./obj_dir/ps2_keyboard_sim +verilator+error+limit+100 \
	| tee /dev/stderr | grep -q "^STATUS: PASS$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
